//--- source/frontend_defines.svh
// Build-time constants for the instruction fetch front end.
// Include this header in any file that needs the address width, the
// reset vector or the prefetch queue depth.

`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Width of fetch and jump addresses
`define FE_ADDR_W 32

// First fetch address after reset
// It must be word aligned because fetches are always whole words
`define FE_RESET_VECTOR 32'h0000_0200

// Number of prefetch queue entries
// Two entries give full throughput with two fetches in flight, and
// a deeper queue gains nothing here
`define FE_QUEUE_DEPTH 2

`endif

//--- source/fetch_bus_pkg.sv
// Types that describe the memory side of the fetch front end.
// Import this package where fetched words, their halfword masks or
// the outstanding fetch counters are handled.

package fetch_bus_pkg;

	// ------------------------------------------------------------------
	// Bus payload
	// ------------------------------------------------------------------

	// One data word as returned by the memory port
	typedef logic [31:0] fetch_word_t;

	// Halfword valid mask of a fetched word
	// Bit 0 covers bits [15:0], bit 1 covers bits [31:16]
	// After a jump to an odd halfword only bit 1 is set for the first word
	typedef logic [1:0] hw_mask_t;

	// ------------------------------------------------------------------
	// Bus tracking
	// ------------------------------------------------------------------

	// Count of fetches in flight, or of in-flight fetches still to drop
	// Never more than two, so the value 3 is unused
	typedef logic [1:0] pend_cnt_t;

endpackage

//--- source/instr_buf_pkg.sv
// Types that describe the decode side of the fetch front end.
// Import this package where the current instruction register, its
// fill level or its bus error flags are handled.

package instr_buf_pkg;

	// ------------------------------------------------------------------
	// Instruction parcels
	// ------------------------------------------------------------------

	// One 16-bit parcel; a full instruction is one or two of these
	typedef logic [15:0] halfword_t;

	// Number of valid halfwords
	// Serves as the CIR level, the decode consumption count and the
	// level of the three-halfword assembly buffer
	typedef logic [1:0] cir_level_t;

	// ------------------------------------------------------------------
	// Error tracking
	// ------------------------------------------------------------------

	// Bus error per CIR halfword
	// Bit 0 flags cir[15:0], bit 1 flags cir[31:16]
	typedef logic [1:0] hw_err_t;

endpackage

//--- source/fetch_request.sv
// Address side of the fetch front end.
// Drives word fetch addresses to the memory port, holds an address
// phase until it is accepted, counts fetches in flight and marks
// which returning words must be dropped after a jump. Also supplies
// the halfword mask that goes with the next kept data word.

`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_request (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`FE_ADDR_W-1:0]   jump_target,
	input  logic                    jump_target_vld,
	output logic                    jump_target_rdy,
	output logic [`FE_ADDR_W-1:0]   mem_addr,
	output logic                    mem_addr_vld,
	input  logic                    mem_addr_rdy,
	input  logic                    mem_data_vld,
	input  logic                    queue_full,
	input  logic                    queue_almost_full,
	output logic                    jump_now,
	output logic                    flush_pending,
	output fetch_bus_pkg::hw_mask_t data_hwvld
);

import fetch_bus_pkg::*;

localparam int AW = `FE_ADDR_W;

// Next word to fetch; runs ahead of decode in word steps
logic [AW-1:0] fetch_addr;
logic [AW-1:0] req_addr;
logic          req_vld;
logic          addr_hold;
logic          reset_holdoff;
logic          addr_issue;
logic          pend_full;
logic          fetch_stall;
pend_cnt_t     pend_cnt;
pend_cnt_t     flush_cnt;

// ----------------------------------------------------------------------
// Address phase
// ----------------------------------------------------------------------

// A jump is refused only while an address phase must stay stable
assign jump_target_rdy = !addr_hold;
assign jump_now        = jump_target_vld && jump_target_rdy;

// Queue space must cover every word that is still in flight
assign pend_full   = pend_cnt == pend_cnt_t'(2);
assign fetch_stall = queue_full || (queue_almost_full && pend_cnt != '0) || pend_full;

// A held request wins, then a jump target, then sequential fetch
// With two fetches in flight a jump is taken but its address is
// issued later from fetch_addr
always_comb begin
	req_addr = fetch_addr;
	req_vld  = 1'b0;
	if (addr_hold) begin
		req_vld = 1'b1;
	end else if (jump_target_vld) begin
		req_addr = {jump_target[AW-1:2], 2'b00};
		req_vld  = !pend_full;
	end else begin
		req_vld = !fetch_stall;
	end
end

// No request in the first cycle after reset release
assign mem_addr     = req_addr;
assign mem_addr_vld = req_vld && !reset_holdoff;
assign addr_issue   = mem_addr_vld && mem_addr_rdy;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		reset_holdoff <= 1'b1;
		addr_hold     <= 1'b0;
		fetch_addr    <= `FE_RESET_VECTOR;
	end else begin
		reset_holdoff <= 1'b0;
		// Keep address and valid until the cycle after ready
		addr_hold <= mem_addr_vld && !mem_addr_rdy;
		if (jump_now) begin
			// Skip past the target word if it went straight out this cycle
			fetch_addr <= {jump_target[AW-1:2] + (AW-2)'(addr_issue), 2'b00};
		end else if (addr_issue) begin
			fetch_addr <= fetch_addr + AW'(4);
		end
	end
end

// ----------------------------------------------------------------------
// Data phase tracking
// ----------------------------------------------------------------------

// Words return in order, so every word in flight at a jump is older
// than the target word and gets dropped
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pend_cnt   <= '0;
		flush_cnt  <= '0;
		data_hwvld <= 2'b11;
	end else begin
		pend_cnt <= pend_cnt + pend_cnt_t'(addr_issue) - pend_cnt_t'(mem_data_vld);
		if (jump_now) begin
			flush_cnt <= pend_cnt - pend_cnt_t'(mem_data_vld);
		end else if (flush_cnt != '0 && mem_data_vld) begin
			flush_cnt <= flush_cnt - pend_cnt_t'(1);
		end
		// The first kept word after an odd jump has no valid low half
		if (jump_now) begin
			data_hwvld <= {1'b1, !jump_target[1]};
		end else if (mem_data_vld && flush_cnt == '0) begin
			data_hwvld <= 2'b11;
		end
	end
end

assign flush_pending = flush_cnt != '0;

endmodule

//--- source/prefetch_queue.sv
// Prefetch queue between the memory port and instruction assembly.
// A small shifting queue: entry 0 is always the oldest word, valid
// entries stay packed from entry 0 up, and a pop moves everything
// down by one. Each entry carries its word, halfword mask and error.

`timescale 1ns/1ps
`include "frontend_defines.svh"

module prefetch_queue (
	input  logic                       clk,
	input  logic                       rst_n,
	input  fetch_bus_pkg::fetch_word_t mem_data,
	input  logic                       mem_data_err,
	input  fetch_bus_pkg::hw_mask_t    data_hwvld,
	input  logic                       push,
	input  logic                       pop,
	input  logic                       jump_now,
	output fetch_bus_pkg::fetch_word_t head_word,
	output fetch_bus_pkg::hw_mask_t    head_hwvld,
	output logic                       head_err,
	output logic                       queue_empty,
	output logic                       queue_full,
	output logic                       queue_almost_full
);

import fetch_bus_pkg::*;

localparam int DEPTH = `FE_QUEUE_DEPTH;

fetch_word_t      q_word   [DEPTH];
hw_mask_t         q_hwvld  [DEPTH];
logic [DEPTH-1:0] q_err;

// Contents of the entry above each entry, the bus for the top one
fetch_word_t      up_word  [DEPTH];
hw_mask_t         up_hwvld [DEPTH];
logic [DEPTH-1:0] up_err;

// Entry i is valid at bit i+1; bit 0 is a permanently full floor
// and the top bit a permanently empty ceiling
logic [DEPTH+1:0] ext_vld;

always_comb begin
	ext_vld[0]       = 1'b1;
	ext_vld[DEPTH+1] = 1'b0;
	for (int i = 0; i < DEPTH; i++) begin
		ext_vld[i + 1] = |q_hwvld[i];
	end
	for (int i = 0; i < DEPTH - 1; i++) begin
		up_word[i]  = q_word[i + 1];
		up_hwvld[i] = q_hwvld[i + 1];
		up_err[i]   = q_err[i + 1];
	end
	up_word[DEPTH-1]  = mem_data;
	up_hwvld[DEPTH-1] = '0;
	up_err[DEPTH-1]   = mem_data_err;
end

// Payload moves on a pop, or when a push lands in an empty slot
// A slot with a valid neighbour above takes that neighbour, else the bus
always_ff @(posedge clk) begin
	for (int i = 0; i < DEPTH; i++) begin
		if (pop || (push && !ext_vld[i + 1])) begin
			q_word[i] <= ext_vld[i + 2] ? up_word[i] : mem_data;
			q_err[i]  <= ext_vld[i + 2] ? up_err[i] : mem_data_err;
		end
	end
end

// The halfword masks double as entry valid flags
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < DEPTH; i++) begin
			q_hwvld[i] <= '0;
		end
	end else begin
		for (int i = 0; i < DEPTH; i++) begin
			if (jump_now) begin
				q_hwvld[i] <= '0;
			end else if (ext_vld[i + 2] && pop) begin
				q_hwvld[i] <= up_hwvld[i];
			end else if (ext_vld[i + 1] && pop) begin
				// Youngest entry popped, and a push refills the vacated slot
				q_hwvld[i] <= push ? data_hwvld : '0;
			end else if (!ext_vld[i + 1] && ext_vld[i] && push && !pop) begin
				q_hwvld[i] <= data_hwvld;
			end
		end
	end
end

assign head_word         = q_word[0];
assign head_hwvld        = q_hwvld[0];
assign head_err          = q_err[0];
assign queue_empty       = !ext_vld[1];
assign queue_full        = ext_vld[DEPTH];
assign queue_almost_full = ext_vld[DEPTH-1];

endmodule

//--- source/instr_assembly.sv
// Instruction assembly for the fetch front end.
// Holds the current instruction register and one spare halfword.
// Each cycle the halfwords that decode consumed are shifted out and
// a fresh fetch word, from the queue head or straight off the bus,
// is laid on top when there is room for it. Bus errors follow their
// halfwords through the same shifts.

`timescale 1ns/1ps

module instr_assembly (
	input  logic                       clk,
	input  logic                       rst_n,
	input  fetch_bus_pkg::fetch_word_t mem_data,
	input  logic                       mem_data_err,
	input  logic                       mem_data_vld,
	input  fetch_bus_pkg::hw_mask_t    data_hwvld,
	input  logic                       flush_pending,
	input  logic                       jump_now,
	input  fetch_bus_pkg::fetch_word_t head_word,
	input  fetch_bus_pkg::hw_mask_t    head_hwvld,
	input  logic                       head_err,
	input  logic                       queue_empty,
	output logic                       push,
	output logic                       pop,
	output logic [31:0]                cir,
	output instr_buf_pkg::cir_level_t  cir_vld,
	input  instr_buf_pkg::cir_level_t  cir_use,
	output instr_buf_pkg::hw_err_t     cir_err
);

import fetch_bus_pkg::*;
import instr_buf_pkg::*;

localparam int HW = $bits(halfword_t);

// Spare halfword above the CIR, and the level of {hwbuf, cir}
halfword_t   hwbuf;
cir_level_t  buf_level;
logic [2:0]  buf_err;

fetch_word_t fetch_data;
hw_mask_t    fetch_hwvld;
logic        fetch_err;
logic        fetch_vld;
logic [2*HW-1:0] fetch_aligned;
logic [3*HW-1:0] data_shifted;
logic [3*HW-1:0] data_next;
logic [2:0]  err_shifted;
logic [2:0]  err_next;
cir_level_t  level_no_fetch;
cir_level_t  fill_amount;
cir_level_t  level_next;
logic        room_for_fetch;

// ----------------------------------------------------------------------
// Fetch word selection
// ----------------------------------------------------------------------

// The bus bypasses the queue whenever the queue holds nothing
assign fetch_data  = queue_empty ? mem_data : head_word;
assign fetch_hwvld = queue_empty ? data_hwvld : head_hwvld;
assign fetch_err   = queue_empty ? mem_data_err : head_err;
assign fetch_vld   = !queue_empty || (mem_data_vld && !flush_pending);

// Move the upper half down when the low half is not valid
assign fetch_aligned = {fetch_data[HW +: HW],
	fetch_hwvld[0] ? fetch_data[0 +: HW] : fetch_data[HW +: HW]};

// ----------------------------------------------------------------------
// Shift and overlay
// ----------------------------------------------------------------------

// Drop consumed halfwords; upper slots are don't-care once freed
assign data_shifted =
	cir_use[1] ? {hwbuf, cir[HW +: HW], hwbuf} :
	cir_use[0] ? {hwbuf, hwbuf, cir[HW +: HW]} :
	             {hwbuf, cir};

assign err_shifted =
	cir_use[1] ? buf_err >> 2 :
	cir_use[0] ? buf_err >> 1 : buf_err;

assign level_no_fetch = buf_level - cir_use;

// A whole word fits below level 2, a lone halfword fits below level 3
assign room_for_fetch = level_no_fetch <= ((fetch_hwvld != 2'b11) ? cir_level_t'(2) :
	cir_level_t'(1));

assign pop  = room_for_fetch && !queue_empty;
// A bypassed word must not also be written to the queue
assign push = mem_data_vld && !flush_pending && !(room_for_fetch && queue_empty);

// Lay the fresh word just above the halfwords that remain
always_comb begin
	if (!room_for_fetch) begin
		data_next = data_shifted;
		err_next  = err_shifted;
	end else if (level_no_fetch[1]) begin
		data_next = {fetch_aligned[0 +: HW], data_shifted[0 +: 2*HW]};
		err_next  = {fetch_err, err_shifted[1:0]};
	end else if (level_no_fetch[0]) begin
		data_next = {fetch_aligned, data_shifted[0 +: HW]};
		err_next  = {{2{fetch_err}}, err_shifted[0]};
	end else begin
		data_next = {data_shifted[2*HW +: HW], fetch_aligned};
		err_next  = {err_shifted[2], {2{fetch_err}}};
	end
end

assign fill_amount = (room_for_fetch && fetch_vld) ?
	((fetch_hwvld == 2'b11) ? cir_level_t'(2) : cir_level_t'(1)) : '0;

// A jump empties the buffer outright
assign level_next = jump_now ? '0 : level_no_fetch + fill_amount;

// ----------------------------------------------------------------------
// Registers
// ----------------------------------------------------------------------

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		buf_level <= '0;
		cir_vld   <= '0;
		buf_err   <= '0;
	end else begin
		buf_level <= level_next;
		// Decode only ever sees up to two halfwords
		cir_vld   <= (level_next == cir_level_t'(3)) ? cir_level_t'(2) : level_next;
		buf_err   <= err_next;
	end
end

always_ff @(posedge clk) begin
	{hwbuf, cir} <= data_next;
end

assign cir_err = buf_err[1:0];

endmodule

//--- source/fetch_frontend.sv
// Top level of the instruction fetch front end.
// Connects the address side, the prefetch queue and the instruction
// assembly unit to the memory port, the jump port and decode.

`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_frontend (
	input  logic                       clk,
	input  logic                       rst_n,
	// Memory port
	output logic [`FE_ADDR_W-1:0]      mem_addr,
	output logic                       mem_addr_vld,
	input  logic                       mem_addr_rdy,
	input  fetch_bus_pkg::fetch_word_t mem_data,
	input  logic                       mem_data_err,
	input  logic                       mem_data_vld,
	// Jump port
	input  logic [`FE_ADDR_W-1:0]      jump_target,
	input  logic                       jump_target_vld,
	output logic                       jump_target_rdy,
	// Decode port
	output logic [31:0]                cir,
	output instr_buf_pkg::cir_level_t  cir_vld,
	input  instr_buf_pkg::cir_level_t  cir_use,
	output instr_buf_pkg::hw_err_t     cir_err
);

import fetch_bus_pkg::*;

logic        jump_now;
logic        flush_pending;
hw_mask_t    data_hwvld;
fetch_word_t head_word;
hw_mask_t    head_hwvld;
logic        head_err;
logic        queue_empty;
logic        queue_full;
logic        queue_almost_full;
logic        push;
logic        pop;

fetch_request u_fetch_request (
	.clk, .rst_n, .jump_target, .jump_target_vld, .jump_target_rdy,
	.mem_addr, .mem_addr_vld, .mem_addr_rdy, .mem_data_vld,
	.queue_full, .queue_almost_full, .jump_now, .flush_pending, .data_hwvld
);

prefetch_queue u_prefetch_queue (
	.clk, .rst_n, .mem_data, .mem_data_err, .data_hwvld, .push, .pop, .jump_now,
	.head_word, .head_hwvld, .head_err, .queue_empty, .queue_full, .queue_almost_full
);

// Decides push and pop, since both depend on room in the CIR
instr_assembly u_instr_assembly (
	.clk, .rst_n, .mem_data, .mem_data_err, .mem_data_vld, .data_hwvld,
	.flush_pending, .jump_now, .head_word, .head_hwvld, .head_err, .queue_empty,
	.push, .pop, .cir, .cir_vld, .cir_use, .cir_err
);

endmodule

//--- bench/fetch_frontend_asserts.sv
// Concurrent checks on the fetch front end internals.
// Bound into fetch_frontend by the testbench, with the outstanding and
// flush counters of the address side and the entry valid bits of the
// prefetch queue brought in through the bind connection.

`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_frontend_asserts (
	input logic                       clk,
	input logic                       rst_n,
	input fetch_bus_pkg::pend_cnt_t   pend_cnt,
	input fetch_bus_pkg::pend_cnt_t   flush_cnt,
	input logic                       mem_data_vld,
	input logic [`FE_QUEUE_DEPTH-1:0] entry_vld
);

import fetch_bus_pkg::*;

// Words to drop are always among the words in flight
a_flush_within_pend: assert property (@(posedge clk) disable iff (!rst_n)
	flush_cnt <= pend_cnt)
	else $error("flush count %0d above outstanding count %0d", flush_cnt, pend_cnt);

a_pend_limit: assert property (@(posedge clk) disable iff (!rst_n)
	pend_cnt <= pend_cnt_t'(2))
	else $error("outstanding count %0d above two", pend_cnt);

// Every returned word answers an address already accepted
a_data_has_fetch: assert property (@(posedge clk) disable iff (!rst_n)
	mem_data_vld |-> pend_cnt != '0)
	else $error("memory data returned with no fetch outstanding");

// Valid entries sit packed from entry 0 upward
a_queue_compact: assert property (@(posedge clk) disable iff (!rst_n)
	((entry_vld + 1'b1) & entry_vld) == '0)
	else $error("prefetch queue entries not compact: %b", entry_vld);

endmodule

//--- bench/fetch_frontend_tb.sv
// Testbench for the instruction fetch front end.
// Models the memory port with random ready and in-order data, a decode
// stage that consumes whole instructions or stalls at random, and a core
// that takes jumps. Every consumed instruction is checked against a
// reference model of the memory contents walked by a model PC.

`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_frontend_tb;

import fetch_bus_pkg::*;
import instr_buf_pkg::*;

localparam int CLK_PERIOD = 8;
localparam int NUM_INSTR  = 400;
// Words in this byte range come back with a bus error
localparam logic [31:0] ERR_LO = 32'h0000_1400;
localparam logic [31:0] ERR_HI = 32'h0000_1440;

// One decode event, either a consumed instruction or a taken jump
typedef struct packed {
	logic        is_jump;
	logic [31:0] word;
	hw_err_t     err;
	cir_level_t  len;
} obs_t;

logic                  clk;
logic                  rst_n;
logic [`FE_ADDR_W-1:0] mem_addr;
logic                  mem_addr_vld;
logic                  mem_addr_rdy;
fetch_word_t           mem_data;
logic                  mem_data_err;
logic                  mem_data_vld;
logic [`FE_ADDR_W-1:0] jump_target;
logic                  jump_target_vld;
logic                  jump_target_rdy;
logic [31:0]           cir;
cir_level_t            cir_vld;
cir_level_t            cir_use;
hw_err_t               cir_err;

// Knobs set by the main sequence
int          rdy_pct;
int          stall_pct;
logic        jump_req;
logic [31:0] jump_addr;
int          checked;
obs_t        obs_q[$];
logic [31:0] pend_addr[$];
int          pend_due[$];

fetch_frontend dut0 (.*);

bind fetch_frontend fetch_frontend_asserts u_asserts (
	.clk          (clk),
	.rst_n        (rst_n),
	.pend_cnt     (u_fetch_request.pend_cnt),
	.flush_cnt    (u_fetch_request.flush_cnt),
	.mem_data_vld (mem_data_vld),
	.entry_vld    (u_prefetch_queue.ext_vld[`FE_QUEUE_DEPTH:1])
);

// ----------------------------------------------------------------------
// Reference model
// ----------------------------------------------------------------------

// Memory contents are a fixed hash of the word address
function automatic fetch_word_t mem_word(input logic [31:0] addr);
	logic [31:0] h;
	h = {addr[31:2], 2'b00} * 32'h9e37_79b1;
	h = h ^ (h >> 15);
	h = h * 32'h85eb_ca6b;
	return h ^ (h >> 13);
endfunction

function automatic logic word_err(input logic [31:0] addr);
	return addr >= ERR_LO && addr < ERR_HI;
endfunction

function automatic halfword_t halfword_at(input logic [31:0] addr);
	fetch_word_t w;
	w = mem_word(addr);
	return addr[1] ? w[31:16] : w[15:0];
endfunction

// Expected two parcels at pc in bits [31:0], their error flags above
function automatic logic [33:0] expected_instr(input logic [31:0] pc);
	logic [31:0] nxt;
	nxt = pc + 32'd2;
	return {word_err(nxt), word_err(pc), halfword_at(nxt), halfword_at(pc)};
endfunction

task automatic abort_run(input string reason);
	$display("%s", reason);
	$display("RESULT: FAIL");
	$fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
	if (got !== want) begin
		$display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
		abort_run("Wrong value seen on a DUT output");
	end
endtask

// ----------------------------------------------------------------------
// Memory, decode and jump models
// ----------------------------------------------------------------------

// Drives 1 ns after each rising edge and samples the settled outputs 5 ns later
task automatic run_port_models();
	logic        acc;
	logic [31:0] acc_addr;
	logic        hold;
	logic [31:0] hold_addr;
	logic        jump_taken;
	logic        first_seen;
	int          cyc;
	int          due;
	int          last_due;
	cir_level_t  len;
	obs_t        o;
	acc = 1'b0;
	hold = 1'b0;
	jump_taken = 1'b0;
	first_seen = 1'b0;
	cyc = 0;
	last_due = 0;
	forever begin
		@(posedge clk);
		cyc++;
		#1;
		// An address taken at this edge returns 1 to 3 cycles after its
		// address cycle, never ahead of an older one
		if (acc) begin
			due = cyc + $urandom_range(0, 2);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			pend_addr.push_back(acc_addr);
			pend_due.push_back(due);
		end
		if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
			mem_data_vld = 1'b1;
			mem_data     = mem_word(pend_addr[0]);
			mem_data_err = word_err(pend_addr[0]);
			pend_addr.delete(0);
			pend_due.delete(0);
		end else begin
			mem_data_vld = 1'b0;
			mem_data     = $urandom;
			mem_data_err = 1'b0;
		end
		mem_addr_rdy = $urandom_range(0, 99) < rdy_pct;
		// A jump taken at the last edge must have emptied the CIR
		if (jump_taken) begin
			check_value("cir_vld", 32'(cir_vld), 32'd0);
			o = '{is_jump: 1'b1, word: jump_target, err: '0, len: '0};
			obs_q.push_back(o);
			jump_target_vld = 1'b0;
			jump_req = 1'b0;
		end else if (jump_req) begin
			jump_target_vld = 1'b1;
			jump_target     = jump_addr;
		end
		// Decode takes a whole instruction or nothing, and holds off while jumping
		cir_use = '0;
		if (!jump_target_vld && cir_vld != '0) begin
			len = (cir[1:0] == 2'b11) ? cir_level_t'(2) : cir_level_t'(1);
			if (cir_vld >= len && $urandom_range(0, 99) >= stall_pct) begin
				cir_use = len;
				o = '{is_jump: 1'b0, word: cir, err: cir_err, len: len};
				obs_q.push_back(o);
			end
		end
		#5;
		// A held address phase keeps both address and valid
		if (hold) begin
			check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd1);
			check_value("mem_addr", mem_addr, hold_addr);
		end
		if (mem_addr_vld && !first_seen) begin
			check_value("mem_addr", mem_addr, `FE_RESET_VECTOR);
			first_seen = 1'b1;
		end
		acc        = mem_addr_vld && mem_addr_rdy;
		acc_addr   = mem_addr;
		hold       = mem_addr_vld && !mem_addr_rdy;
		hold_addr  = mem_addr;
		jump_taken = jump_target_vld && jump_target_rdy;
		if (pend_due.size() + int'(acc) > 2) begin
			abort_run("More than two fetches are outstanding on the memory port");
		end
	end
endtask

// Walks the model PC through the stream and checks each consumed instruction
initial begin : compare_stream
	obs_t        o;
	logic [31:0] pc;
	logic [33:0] ref_val;
	pc = `FE_RESET_VECTOR;
	forever begin
		@(negedge clk);
		while (obs_q.size() != 0) begin
			o = obs_q.pop_front();
			if (o.is_jump) begin
				pc = o.word;
			end else begin
				ref_val = expected_instr(pc);
				if (o.len == cir_level_t'(2)) begin
					check_value("cir", o.word, ref_val[31:0]);
					check_value("cir_err", 32'(o.err), 32'(ref_val[33:32]));
				end else begin
					check_value("cir[15:0]", 32'(o.word[15:0]), 32'(ref_val[15:0]));
					check_value("cir_err[0]", 32'(o.err[0]), 32'(ref_val[32]));
				end
				pc = pc + 32'(o.len) * 32'd2;
				checked++;
			end
		end
	end
end

// ----------------------------------------------------------------------
// Sequence
// ----------------------------------------------------------------------

task automatic wait_instr(input int n);
	int goal;
	goal = checked + n;
	wait (checked >= goal);
endtask

task automatic take_jump(input logic [31:0] target, input int n);
	jump_addr = target;
	jump_req  = 1'b1;
	wait (jump_req == 1'b0);
	wait_instr(n);
endtask

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

// Generous budget of 40 cycles per instruction
initial begin : watchdog
	repeat (NUM_INSTR * 40) @(posedge clk);
	abort_run("Timeout: the instruction stream stopped making progress");
end

initial begin : main_sequence
	logic [31:0] target;
	void'($urandom(38));
	rst_n = 1'b0;
	mem_addr_rdy = 1'b0;
	mem_data = '0;
	mem_data_err = 1'b0;
	mem_data_vld = 1'b0;
	jump_target = '0;
	jump_target_vld = 1'b0;
	cir_use = '0;
	rdy_pct = 100;
	stall_pct = 0;
	jump_req = 1'b0;
	jump_addr = '0;
	checked = 0;
	fork
		run_port_models();
	join_none
	repeat (16) @(posedge clk);
	#1;
	rst_n = 1'b1;
	#5;
	// First cycle out of reset has no request
	check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd0);
	check_value("jump_target_rdy", 32'(jump_target_rdy), 32'd1);
	check_value("cir_vld", 32'(cir_vld), 32'd0);
	wait_instr(60);
	rdy_pct = 60;
	stall_pct = 40;
	wait_instr(100);
	// Decode stops, the queue fills and fetch goes quiet
	stall_pct = 100;
	repeat (30) @(posedge clk);
	#6;
	check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd0);
	stall_pct = 30;
	wait_instr(60);
	// Odd target just below the error window, then run through it
	take_jump(32'h0000_13f2, 40);
	for (int i = 0; i < 10; i++) begin
		target = 32'h0000_0800 + ($urandom_range(0, 2047) << 1);
		target[1] = i[0];
		take_jump(target, $urandom_range(3, 12));
	end
	$display("RESULT: PASS");
	$finish;
end

endmodule

//--- sources.f
+incdir+source
source/fetch_bus_pkg.sv
source/instr_buf_pkg.sv
source/fetch_request.sv
source/prefetch_queue.sv
source/instr_assembly.sv
source/fetch_frontend.sv
bench/fetch_frontend_asserts.sv
bench/fetch_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the fetch front end with its testbench and run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module fetch_frontend_tb

status=0
output=$(./obj_dir/Vfetch_frontend_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
	exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
